// File: hdl/fix_msg_pkg.sv
package fix_msg_pkg;

	// one byte of the outgoing message
	typedef logic [7:0] msg_byte_t;

	// ******************************
	// framing constants
	// ******************************

	// field separator
	localparam msg_byte_t SOH = 8'h01;

	// host command that opens a session
	localparam msg_byte_t CONNECT_CMD = 8'hdd;

	// fixed logon length in bytes
	localparam int MSG_LEN = 16;

	// byte positions filled at build time
	localparam int SENDER_POS = 13;
	localparam int CSUM_POS = 15;

	// logon skeleton, element 0 goes out first
	// placeholders at SENDER_POS and CSUM_POS are overwritten
	localparam logic [0:MSG_LEN-1][7:0] MSG_TEMPLATE = {
		"8=FIX.4.2",
		SOH,
		"49=",
		8'h00,
		SOH,
		8'h00
	};

endpackage

// File: hdl/host_reg_pkg.sv
package host_reg_pkg;

	// ******************************
	// host register map
	// ******************************

	// status byte, read only
	localparam logic [2:0] ADDR_STATUS = 3'd0;
	// message byte at read pointer, read advances pointer
	localparam logic [2:0] ADDR_RDATA = 3'd1;
	// index of last stored byte
	localparam logic [2:0] ADDR_FINAL = 3'd2;
	// sender identifier, write only
	localparam logic [2:0] ADDR_SENDER = 3'd3;
	// connect command, write only
	localparam logic [2:0] ADDR_CONN = 3'd6;

	// one host bus beat
	typedef struct packed {
		logic [2:0] address;
		logic       read;
		logic       write;
		logic [7:0] writedata;
	} host_req_t;

	// status register layout
	typedef struct packed {
		// upper bits read as zero
		logic [5:0] zero;
		// unread bytes remain
		logic       ready_to_read;
		// message fully stored
		logic       done;
	} status_t;

endpackage

// File: hdl/fix_host_slave.sv
module fix_host_slave (
	input  logic                    clk,
	input  logic                    reset,
	// host port
	input  host_reg_pkg::host_req_t host_req,
	output logic [7:0]              slave_readdata,
	// engine side
	input  logic                    fix_message_sent,
	input  logic                    ready_to_read,
	input  logic [7:0]              final_index,
	input  fix_msg_pkg::msg_byte_t  data_out_2,
	output logic                    read_request,
	output logic [7:0]              session_initiate,
	output logic [7:0]              sender_id
);
	import host_reg_pkg::*;
	import fix_msg_pkg::*;

	// done flag of status
	logic done;
	// assembled status byte
	status_t status;
	// selected read value before the output register
	logic [7:0] read_mux;

	// ******************************
	// read side
	// ******************************

	assign status = '{zero: 6'd0, ready_to_read: ready_to_read, done: done};

	// register map decode, unmapped and write-only read as 0
	always_comb
	begin
		case (host_req.address)
			ADDR_STATUS: read_mux = status;
			ADDR_RDATA:  read_mux = data_out_2;
			ADDR_FINAL:  read_mux = final_index;
			default:     read_mux = 8'h00;
		endcase
	end

	// capture on read strobe, hold until next read
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			slave_readdata <= 8'h00;
		else if (host_req.read)
			slave_readdata <= read_mux;
	end

	// buffer pointer steps with every RDATA read
	assign read_request = host_req.read && (host_req.address == ADDR_RDATA);

	// ******************************
	// write side
	// ******************************

	// sender byte, kept until rewritten
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			sender_id <= 8'h00;
		else if (host_req.write && (host_req.address == ADDR_SENDER))
			sender_id <= host_req.writedata;
	end

	// connect byte lives for one cycle only
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			session_initiate <= 8'h00;
		else if (host_req.write && (host_req.address == ADDR_CONN))
			session_initiate <= host_req.writedata;
		else
			session_initiate <= 8'h00;
	end

	// done set by the engine, a fresh connect wins over a late set
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			done <= 1'b0;
		else if (session_initiate == CONNECT_CMD)
			done <= 1'b0;
		else if (fix_message_sent)
			done <= 1'b1;
	end

endmodule

// File: hdl/fix_session_fsm.sv
module fix_session_fsm (
	input  logic       clk,
	input  logic       reset,
	// connect byte from the host port
	input  logic [7:0] session_initiate,
	// counter at final byte
	input  logic       last_byte,
	// build control
	output logic       build_start,
	output logic       build_en,
	output logic       fix_message_sent
);
	import fix_msg_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		START,
		BUILD,
		SENT
	} state_t;

	state_t state;
	state_t state_next;

	// only the connect command counts, other bytes are dropped
	logic connect;

	assign connect = (session_initiate == CONNECT_CMD);

	// ******************************
	// next state
	// ******************************

	always_comb
	begin
		state_next = state;
		// reconnect restarts from any state
		if (connect)
			state_next = START;
		else
		begin
			case (state)
				IDLE:
					state_next = IDLE;
				START:
					state_next = BUILD;
				BUILD:
				begin
					// final byte composed this cycle
					if (last_byte)
						state_next = SENT;
				end
				SENT:
					state_next = IDLE;
				default:
					state_next = IDLE;
			endcase
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			state <= IDLE;
		else
			state <= state_next;
	end

	// ******************************
	// outputs, decoded from state
	// ******************************

	// one cycle, clears counter, checksum and buffer
	assign build_start = (state == START);

	// one byte per cycle while building
	assign build_en = (state == BUILD);

	// single pulse after the last byte
	assign fix_message_sent = (state == SENT);

endmodule

// File: hdl/fix_byte_counter.sv
module fix_byte_counter #(
	parameter int DEPTH = 16
) (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     clear,
	input  logic                     enable,
	output logic [$clog2(DEPTH)-1:0] index,
	output logic                     last_byte
);
	import fix_msg_pkg::*;

	localparam int IW = $clog2(DEPTH);

	// terminal count, last message byte
	localparam logic [IW-1:0] LAST = IW'(MSG_LEN - 1);

	assign last_byte = (index == LAST);

	// step while building, park at the terminal count
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			index <= '0;
		else if (clear)
			index <= '0;
		else if (enable && !last_byte)
			index <= index + 1'b1;
	end

endmodule

// File: hdl/fix_msg_composer.sv
module fix_msg_composer (
	input  logic                                    clk,
	input  logic                                    reset,
	// new build
	input  logic                                    clear,
	// compose one byte this cycle
	input  logic                                    enable,
	input  logic [$clog2(fix_msg_pkg::MSG_LEN)-1:0] index,
	input  logic [7:0]                              sender_id,
	// buffer write port
	output logic                                    wr_en,
	output logic [$clog2(fix_msg_pkg::MSG_LEN)-1:0] wr_addr,
	output fix_msg_pkg::msg_byte_t                  wr_data
);
	import fix_msg_pkg::*;

	// running sum mod 256 of bytes so far
	msg_byte_t csum;
	// byte for the current index
	msg_byte_t byte_next;

	// ******************************
	// byte select
	// ******************************

	always_comb
	begin
		if (index == SENDER_POS)
			byte_next = sender_id;
		else if (index == CSUM_POS)
			byte_next = csum;
		else
			byte_next = MSG_TEMPLATE[index];
	end

	// checksum accumulator and write strobe
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wr_en <= 1'b0;
			csum <= 8'h00;
		end
		else if (clear)
		begin
			wr_en <= 1'b0;
			csum <= 8'h00;
		end
		else
		begin
			wr_en <= enable;
			// checksum byte does not add to itself
			if (enable && (index != CSUM_POS))
				csum <= csum + byte_next;
		end
	end

	// address and data follow the strobe
	always_ff @(posedge clk)
	begin
		if (enable)
		begin
			wr_addr <= index;
			wr_data <= byte_next;
		end
	end

endmodule

// File: hdl/fix_msg_buffer.sv
module fix_msg_buffer #(
	parameter int DEPTH = 16
) (
	input  logic                     clk,
	input  logic                     reset,
	// new build, drops the old message
	input  logic                     clear,
	// composer write port
	input  logic                     wr_en,
	input  logic [$clog2(DEPTH)-1:0] wr_addr,
	input  fix_msg_pkg::msg_byte_t   wr_data,
	// host read side
	input  logic                     read_request,
	output fix_msg_pkg::msg_byte_t   data_out_2,
	output logic [7:0]               final_index,
	output logic                     ready_to_read
);
	import fix_msg_pkg::*;

	localparam int AW = $clog2(DEPTH);

	msg_byte_t mem [DEPTH];

	// next byte for the host
	logic [7:0] rd_ptr;
	// set by first write after clear
	logic valid;
	// write address at the width of final_index
	logic [7:0] wr_addr_ext;

	assign wr_addr_ext = 8'(wr_addr);

	// storage
	always_ff @(posedge clk)
	begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// highest written address and valid flag
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			final_index <= 8'h00;
			valid <= 1'b0;
		end
		else if (clear)
		begin
			final_index <= 8'h00;
			valid <= 1'b0;
		end
		else if (wr_en)
		begin
			valid <= 1'b1;
			if (!valid || (wr_addr_ext > final_index))
				final_index <= wr_addr_ext;
		end
	end

	// ******************************
	// read pointer
	// ******************************

	assign ready_to_read = valid && (rd_ptr <= final_index);

	// past the end reads as zero
	assign data_out_2 = ready_to_read ? mem[rd_ptr[AW-1:0]] : 8'h00;

	// stops once the last byte is taken
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			rd_ptr <= 8'h00;
		else if (clear)
			rd_ptr <= 8'h00;
		else if (read_request && ready_to_read)
			rd_ptr <= rd_ptr + 8'd1;
	end

endmodule

// File: hdl/fix_engine_top.sv
module fix_engine_top #(
	// buffer size, at least the message length
	parameter int DEPTH = 16
) (
	input  logic                    clk,
	input  logic                    reset,
	input  host_reg_pkg::host_req_t host_req,
	output logic [7:0]              slave_readdata
);
	import fix_msg_pkg::*;

	localparam int AW = $clog2(DEPTH);
	localparam int MW = $clog2(MSG_LEN);

	// host port to engine
	logic [7:0] session_initiate;
	logic [7:0] sender_id;
	logic read_request;
	// session control
	logic build_start;
	logic build_en;
	logic fix_message_sent;
	logic last_byte;
	logic [AW-1:0] byte_index;
	// composer to buffer
	logic wr_en;
	logic [MW-1:0] wr_addr;
	msg_byte_t wr_data;
	// buffer back to host port
	msg_byte_t data_out_2;
	logic [7:0] final_index;
	logic ready_to_read;

	fix_host_slave u_fix_host_slave (
		.clk              (clk),
		.reset            (reset),
		.host_req         (host_req),
		.slave_readdata   (slave_readdata),
		.fix_message_sent (fix_message_sent),
		.ready_to_read    (ready_to_read),
		.final_index      (final_index),
		.data_out_2       (data_out_2),
		.read_request     (read_request),
		.session_initiate (session_initiate),
		.sender_id        (sender_id)
	);

	fix_session_fsm u_fix_session_fsm (
		.clk              (clk),
		.reset            (reset),
		.session_initiate (session_initiate),
		.last_byte        (last_byte),
		.build_start      (build_start),
		.build_en         (build_en),
		.fix_message_sent (fix_message_sent)
	);

	fix_byte_counter #(
		.DEPTH (DEPTH)
	) u_fix_byte_counter (
		.clk       (clk),
		.reset     (reset),
		.clear     (build_start),
		.enable    (build_en),
		.index     (byte_index),
		.last_byte (last_byte)
	);

	// index never passes MSG_LEN-1, low bits are enough
	fix_msg_composer u_fix_msg_composer (
		.clk       (clk),
		.reset     (reset),
		.clear     (build_start),
		.enable    (build_en),
		.index     (byte_index[MW-1:0]),
		.sender_id (sender_id),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data)
	);

	fix_msg_buffer #(
		.DEPTH (DEPTH)
	) u_fix_msg_buffer (
		.clk           (clk),
		.reset         (reset),
		.clear         (build_start),
		.wr_en         (wr_en),
		.wr_addr       (AW'(wr_addr)),
		.wr_data       (wr_data),
		.read_request  (read_request),
		.data_out_2    (data_out_2),
		.final_index   (final_index),
		.ready_to_read (ready_to_read)
	);

endmodule

// File: dv/fix_engine_checker.sv
module fix_engine_checker (
	input logic                    clk,
	input logic                    reset,
	input host_reg_pkg::host_req_t host_req,
	input logic [7:0]              slave_readdata
);
	timeunit 1ns;
	timeprecision 1ps;

	// expected read values, in issue order
	logic [7:0] exp_q [$];
	string label_q [$];

	// expectation for the read sampled at the last edge
	logic [7:0] cur_exp;
	string cur_label;
	logic cur_valid = 1'b0;

	// counters
	int test_errors = 0;
	int error_count = 0;
	int tests_run = 0;
	int tests_failed = 0;

	// queued by the stimulus side, one per host read
	function void expect_read(input logic [7:0] value, input string label);
		exp_q.push_back(value);
		label_q.push_back(label);
	endfunction

	function void note_error();
		test_errors++;
		error_count++;
	endfunction

	// ******************************
	// sampling and compare
	// ******************************

	// take the expectation with the read strobe
	always @(posedge clk or posedge reset)
	begin
		if (reset)
			cur_valid = 1'b0;
		else if (host_req.read)
		begin
			if (exp_q.size() == 0)
			begin
				$display("host read at address %0d came with no expected value", host_req.address);
				note_error();
				cur_valid = 1'b0;
			end
			else
			begin
				cur_exp = exp_q.pop_front();
				cur_label = label_q.pop_front();
				cur_valid = 1'b1;
			end
		end
		else
			cur_valid = 1'b0;
	end

	// read data is registered, stable by the falling edge
	always @(negedge clk)
	begin
		if (cur_valid && (slave_readdata !== cur_exp))
		begin
			$display("[ERROR] slave_readdata (%s): expected 0x%02h, got 0x%02h",
				cur_label, cur_exp, slave_readdata);
			note_error();
		end
	end

	// ******************************
	// reporting
	// ******************************

	function void close_test(input int num, input string name);
		tests_run++;
		if (test_errors == 0)
			$display("test %0d %s: passed", num, name);
		else
		begin
			tests_failed++;
			$display("test %0d %s: failed with %0d errors", num, name, test_errors);
		end
		test_errors = 0;
	endfunction

	function void final_report();
		// reads that were queued but never issued
		if (exp_q.size() != 0)
		begin
			$display("%0d expected reads were never issued", exp_q.size());
			error_count++;
		end
		$display("summary: %0d tests, %0d passed, %0d failed, %0d errors",
			tests_run, tests_run - tests_failed, tests_failed, error_count);
	endfunction

endmodule

// File: dv/fix_engine_tb.sv
module fix_engine_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import fix_msg_pkg::*;
	import host_reg_pkg::*;

	localparam int DEPTH = 16;
	localparam int CLK_PERIOD = 100;
	localparam int NUM_TESTS = 6;
	localparam int CYCLES_PER_TEST = 60;
	localparam int TIMEOUT = NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD;
	// sessions in the repeated test
	localparam int SESSIONS = 3;
	// x^32 + x^22 + x^2 + x + 1, right shifting
	localparam logic [31:0] LFSR_TAPS = 32'h80200003;

	logic clk;
	logic reset;
	host_req_t host_req;
	logic [7:0] slave_readdata;

	logic [31:0] lfsr;
	// expected logon bytes
	msg_byte_t exp_msg [MSG_LEN];

	fix_engine_top #(
		.DEPTH (DEPTH)
	) u_fix_engine_top (
		.clk            (clk),
		.reset          (reset),
		.host_req       (host_req),
		.slave_readdata (slave_readdata)
	);

	fix_engine_checker u_checker (
		.clk            (clk),
		.reset          (reset),
		.host_req       (host_req),
		.slave_readdata (slave_readdata)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// ******************************
	// random source
	// ******************************

	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		if (state[0])
			return (state >> 1) ^ LFSR_TAPS;
		return state >> 1;
	endfunction

	// one step per bit taken
	function automatic logic [31:0] take_bits(input int nbits);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < nbits; i++)
		begin
			value = {value[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
		return value;
	endfunction

	// ******************************
	// expected message
	// ******************************

	function automatic void build_model(input msg_byte_t sender);
		logic [7:0] sum;
		for (int i = 0; i < MSG_LEN; i++)
			exp_msg[i] = MSG_TEMPLATE[i];
		exp_msg[SENDER_POS] = sender;
		// raw byte sum of everything before the checksum
		sum = 8'h00;
		for (int i = 0; i < CSUM_POS; i++)
			sum = sum + exp_msg[i];
		exp_msg[CSUM_POS] = sum;
	endfunction

	// ******************************
	// bus tasks, entered and left on a falling edge
	// ******************************

	task automatic apply_reset();
		reset = 1'b1;
		host_req = '0;
		repeat (2) @(negedge clk);
		reset = 1'b0;
	endtask

	task automatic idle(input int cycles);
		host_req = '0;
		repeat (cycles) @(negedge clk);
	endtask

	task automatic write_reg(input logic [2:0] addr, input logic [7:0] data);
		host_req.address = addr;
		host_req.read = 1'b0;
		host_req.write = 1'b1;
		host_req.writedata = data;
		@(negedge clk);
		host_req = '0;
	endtask

	task automatic read_reg(input logic [2:0] addr, input logic [7:0] exp, input string label);
		u_checker.expect_read(exp, label);
		host_req.address = addr;
		host_req.read = 1'b1;
		host_req.write = 1'b0;
		host_req.writedata = 8'h00;
		@(negedge clk);
		host_req = '0;
	endtask

	// connect sampled at the edge just before return
	task automatic start_session(input msg_byte_t sender);
		write_reg(ADDR_SENDER, sender);
		write_reg(ADDR_CONN, CONNECT_CMD);
		build_model(sender);
	endtask

	task automatic read_message(input int first, input int count);
		for (int i = first; i < first + count; i++)
			read_reg(ADDR_RDATA, exp_msg[i], $sformatf("RDATA byte %0d", i));
	endtask

	// write-only and unmapped addresses
	task automatic check_unmapped();
		for (int a = 3; a < 8; a++)
			read_reg(3'(a), 8'h00, $sformatf("address %0d", a));
	endtask

	// full readback once the message is done
	task automatic check_done_message();
		read_reg(ADDR_STATUS, 8'h03, "STATUS done");
		read_reg(ADDR_FINAL, 8'(MSG_LEN - 1), "FINAL");
		read_message(0, MSG_LEN);
		read_reg(ADDR_STATUS, 8'h01, "STATUS drained");
		read_reg(ADDR_RDATA, 8'h00, "RDATA past end");
	endtask

	// last compare lands on the falling edge, report after the next rising one
	task automatic end_test(input int num, input string name);
		@(posedge clk);
		u_checker.close_test(num, name);
		@(negedge clk);
	endtask

	// ******************************
	// tests
	// ******************************

	task automatic test_ignored_connect();
		logic [7:0] bogus;
		start_session(msg_byte_t'(take_bits(8)));
		idle(19);
		read_reg(ADDR_STATUS, 8'h03, "STATUS done");
		read_message(0, 5);
		do
			bogus = 8'(take_bits(8));
		while (bogus == CONNECT_CMD);
		write_reg(ADDR_CONN, bogus);
		read_reg(ADDR_STATUS, 8'h03, "STATUS after other byte");
		idle(1);
		read_reg(ADDR_STATUS, 8'h03, "STATUS after other byte");
		read_reg(ADDR_FINAL, 8'(MSG_LEN - 1), "FINAL");
		read_message(5, MSG_LEN - 5);
		read_reg(ADDR_STATUS, 8'h01, "STATUS drained");
	endtask

	task automatic test_sessions();
		for (int s = 0; s < SESSIONS; s++)
		begin
			start_session(msg_byte_t'(take_bits(8)));
			// done drops one edge after the connect
			idle(1);
			read_reg(ADDR_STATUS, 8'h00, "STATUS reconnect");
			if (s == 1)
			begin
				// restart in the middle of the build
				idle(4);
				start_session(msg_byte_t'(take_bits(8)));
				idle(19);
			end
			else
				idle(17);
			check_done_message();
		end
	endtask

	task automatic test_unmapped();
		apply_reset();
		check_unmapped();
		start_session(msg_byte_t'(take_bits(8)));
		// during the build
		idle(3);
		check_unmapped();
		idle(11);
		read_reg(ADDR_STATUS, 8'h03, "STATUS done");
		check_unmapped();
		read_message(0, MSG_LEN);
		check_unmapped();
	endtask

	initial
	begin
		lfsr = 32'h9f9ff365;
		apply_reset();

		read_reg(ADDR_STATUS, 8'h00, "STATUS");
		read_reg(ADDR_FINAL, 8'h00, "FINAL");
		read_reg(ADDR_RDATA, 8'h00, "RDATA");
		end_test(1, "reset values");

		start_session(msg_byte_t'(take_bits(8)));
		// STATUS sampled on the 20th edge after the connect
		idle(19);
		read_reg(ADDR_STATUS, 8'h03, "STATUS done");
		read_reg(ADDR_FINAL, 8'(MSG_LEN - 1), "FINAL");
		end_test(2, "connect and status");

		read_message(0, MSG_LEN);
		read_reg(ADDR_STATUS, 8'h01, "STATUS drained");
		read_reg(ADDR_RDATA, 8'h00, "RDATA past end");
		end_test(3, "message readback");

		test_ignored_connect();
		end_test(4, "ignored connect byte");

		test_sessions();
		end_test(5, "repeated sessions");

		test_unmapped();
		end_test(6, "unmapped reads");

		u_checker.final_report();
		if (u_checker.error_count == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

	// watchdog, budget scales with the number of tests
	initial
	begin
		#(TIMEOUT);
		$display("timeout: the run did not finish within %0d ns", TIMEOUT);
		$display("TEST FAILED");
		$finish;
	end

endmodule

// File: all.f
hdl/fix_msg_pkg.sv
hdl/host_reg_pkg.sv
hdl/fix_host_slave.sv
hdl/fix_session_fsm.sv
hdl/fix_byte_counter.sv
hdl/fix_msg_composer.sv
hdl/fix_msg_buffer.sv
hdl/fix_engine_top.sv
dv/fix_engine_checker.sv
dv/fix_engine_tb.sv
